// File: design/dcache_array.sv
`timescale 1ns/1ns

module dcache_array #(
    parameter int NUM_SETS = 16
) (
    input  logic  clk,
    input  logic  rstn,
    array_if.store arr
);
    localparam int IDX_W      = $clog2(NUM_SETS);
    localparam int TAG_W      = wb_pkg::ADR_W - IDX_W - dcache_pkg::OFFSET_BITS;
    localparam int WORD_IDX_W = $clog2(dcache_pkg::WORDS_PER_LINE);
    localparam int BYTE_BITS  = dcache_pkg::OFFSET_BITS - WORD_IDX_W;
    localparam int LINE_W     = dcache_pkg::WORDS_PER_LINE * wb_pkg::DAT_W;
    localparam int BYTE_W     = wb_pkg::DAT_W / wb_pkg::SEL_W;

    logic [TAG_W-1:0]    tag_mem  [dcache_pkg::NUM_WAYS][NUM_SETS];
    logic [LINE_W-1:0]   data_mem [dcache_pkg::NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q  [dcache_pkg::NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_q  [dcache_pkg::NUM_WAYS];
    // Way to replace next in each set
    logic [NUM_SETS-1:0] lru_q;

    logic [IDX_W-1:0]                idx;
    logic [TAG_W-1:0]                tag;
    logic [WORD_IDX_W-1:0]           word_idx;
    logic [dcache_pkg::NUM_WAYS-1:0] hit_vec;

    assign idx      = arr.addr[dcache_pkg::OFFSET_BITS +: IDX_W];
    assign tag      = arr.addr[wb_pkg::ADR_W-1 -: TAG_W];
    assign word_idx = arr.addr[dcache_pkg::OFFSET_BITS-1:BYTE_BITS];

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[w][idx] && (tag_mem[w][idx] == tag);
        end
    end

    assign arr.hit     = |hit_vec;
    assign arr.hit_way = hit_vec[1];
    assign arr.rdata   = data_mem[arr.hit_way][idx][word_idx*wb_pkg::DAT_W +: wb_pkg::DAT_W];

    // Empty ways are filled before anything is evicted
    assign arr.victim_way = !valid_q[0][idx] ? 1'b0 :
                            !valid_q[1][idx] ? 1'b1 : lru_q[idx];

    assign arr.victim_valid = valid_q[arr.way][idx];
    assign arr.victim_dirty = dirty_q[arr.way][idx];
    assign arr.victim_addr  = {tag_mem[arr.way][idx], idx, {dcache_pkg::OFFSET_BITS{1'b0}}};
    assign arr.victim_line  = data_mem[arr.way][idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            case (arr.cmd)
                dcache_pkg::CMD_STORE: begin
                    dirty_q[arr.way][idx] <= 1'b1;
                    lru_q[idx]            <= ~arr.way;
                end
                dcache_pkg::CMD_FILL: begin
                    valid_q[arr.way][idx] <= 1'b1;
                    dirty_q[arr.way][idx] <= arr.fill_dirty;
                    lru_q[idx]            <= ~arr.way;
                end
                dcache_pkg::CMD_INVALIDATE: begin
                    valid_q[arr.way][idx] <= 1'b0;
                    dirty_q[arr.way][idx] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arr.cmd == dcache_pkg::CMD_FILL) begin
            data_mem[arr.way][idx] <= arr.fill_line;
            tag_mem[arr.way][idx]  <= tag;
        end else if (arr.cmd == dcache_pkg::CMD_STORE) begin
            for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                if (arr.wstrb[b]) begin
                    data_mem[arr.way][idx][word_idx*wb_pkg::DAT_W + b*BYTE_W +: BYTE_W] <=
                        arr.wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl #(
    parameter int NUM_SETS = 16
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     cpu_req,
    input  dcache_pkg::cpu_op_e      cpu_op,
    input  logic [wb_pkg::ADR_W-1:0] cpu_addr,
    input  logic [wb_pkg::DAT_W-1:0] cpu_wdata,
    input  logic [wb_pkg::SEL_W-1:0] cpu_wstrb,
    output logic                     cpu_ready,
    output logic                     cpu_done,
    output logic [wb_pkg::DAT_W-1:0] cpu_rdata,
    array_if.ctrl                    arr,
    line_mem_if.ctrl                 mem
);
    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_LSB    = dcache_pkg::OFFSET_BITS + INDEX_BITS;
    localparam int WORD_IDX_W = $clog2(dcache_pkg::WORDS_PER_LINE);
    localparam int BYTE_BITS  = dcache_pkg::OFFSET_BITS - WORD_IDX_W;
    localparam int LINE_W     = dcache_pkg::WORDS_PER_LINE * wb_pkg::DAT_W;
    localparam int BYTE_W     = wb_pkg::DAT_W / wb_pkg::SEL_W;

    dcache_pkg::ctrl_state_e  state_q, state_d;
    logic                     up_q;
    logic                     accept;

    // Buffered request
    dcache_pkg::cpu_op_e      op_q;
    logic [wb_pkg::ADR_W-1:0] addr_q;
    logic [wb_pkg::DAT_W-1:0] wdata_q;
    logic [wb_pkg::SEL_W-1:0] wstrb_q;

    logic                     way_q;
    logic                     sel_way;
    logic                     maint_valid;
    logic [LINE_W-1:0]        line_q;
    logic [LINE_W-1:0]        merged_line;
    logic                     mem_req_q;
    logic                     mem_we_q;
    logic [WORD_IDX_W-1:0]    word_idx;
    logic [wb_pkg::ADR_W-1:0] refill_addr;

    function automatic logic is_maint(dcache_pkg::cpu_op_e op);
        return op == dcache_pkg::OP_INDEX_INV || op == dcache_pkg::OP_HIT_INV;
    endfunction

    assign word_idx    = addr_q[dcache_pkg::OFFSET_BITS-1:BYTE_BITS];
    assign refill_addr = {addr_q[wb_pkg::ADR_W-1:TAG_LSB],
                          addr_q[TAG_LSB-1:dcache_pkg::OFFSET_BITS],
                          {dcache_pkg::OFFSET_BITS{1'b0}}};

    // Index invalidate names its way with address bit 0
    assign sel_way     = (op_q == dcache_pkg::OP_INDEX_INV) ? addr_q[0] : arr.hit_way;
    assign maint_valid = (op_q == dcache_pkg::OP_INDEX_INV) ? arr.victim_valid : arr.hit;

    // Store data merged into the refilled line
    always_comb begin
        merged_line = line_q;
        if (op_q == dcache_pkg::OP_WRITE) begin
            for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                if (wstrb_q[b]) begin
                    merged_line[word_idx*wb_pkg::DAT_W + b*BYTE_W +: BYTE_W] =
                        wdata_q[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    assign arr.addr       = addr_q;
    assign arr.wdata      = wdata_q;
    assign arr.wstrb      = wstrb_q;
    assign arr.fill_line  = merged_line;
    assign arr.fill_dirty = (op_q == dcache_pkg::OP_WRITE);

    assign mem.req   = mem_req_q;
    assign mem.we    = mem_we_q;
    assign mem.addr  = (state_q == dcache_pkg::WRITEBACK) ? arr.victim_addr : refill_addr;
    assign mem.wline = arr.victim_line;

    assign cpu_rdata = (state_q == dcache_pkg::LOOKUP) ? arr.rdata :
                       line_q[word_idx*wb_pkg::DAT_W +: wb_pkg::DAT_W];

    always_comb begin
        state_d   = state_q;
        cpu_ready = 1'b0;
        cpu_done  = 1'b0;
        accept    = 1'b0;
        arr.cmd   = dcache_pkg::CMD_NONE;
        arr.way   = way_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                cpu_ready = up_q;
                if (cpu_req && up_q) begin
                    accept  = 1'b1;
                    state_d = is_maint(cpu_op) ? dcache_pkg::MAINT : dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (arr.hit) begin
                    cpu_done = 1'b1;
                    arr.way  = arr.hit_way;
                    if (op_q == dcache_pkg::OP_WRITE) begin
                        arr.cmd = dcache_pkg::CMD_STORE;
                        state_d = dcache_pkg::IDLE;
                    end else begin
                        // Read hits take the next request straight away
                        cpu_ready = 1'b1;
                        if (cpu_req) begin
                            accept  = 1'b1;
                            state_d = is_maint(cpu_op) ? dcache_pkg::MAINT : dcache_pkg::LOOKUP;
                        end else begin
                            state_d = dcache_pkg::IDLE;
                        end
                    end
                end else begin
                    arr.way = arr.victim_way;
                    if (arr.victim_valid && arr.victim_dirty) begin
                        state_d = dcache_pkg::WRITEBACK;
                    end else begin
                        state_d = dcache_pkg::REFILL;
                    end
                end
            end
            dcache_pkg::WRITEBACK: begin
                if (mem.done) begin
                    if (is_maint(op_q)) begin
                        arr.cmd = dcache_pkg::CMD_INVALIDATE;
                        state_d = dcache_pkg::DONE;
                    end else begin
                        state_d = dcache_pkg::REFILL;
                    end
                end
            end
            dcache_pkg::REFILL: begin
                if (mem.done) begin
                    state_d = dcache_pkg::COMMIT;
                end
            end
            dcache_pkg::COMMIT: begin
                arr.cmd = dcache_pkg::CMD_FILL;
                state_d = dcache_pkg::DONE;
            end
            dcache_pkg::MAINT: begin
                arr.way = sel_way;
                if (maint_valid && arr.victim_dirty) begin
                    state_d = dcache_pkg::WRITEBACK;
                end else begin
                    if (maint_valid) begin
                        arr.cmd = dcache_pkg::CMD_INVALIDATE;
                    end
                    state_d = dcache_pkg::DONE;
                end
            end
            dcache_pkg::DONE: begin
                cpu_done = 1'b1;
                state_d  = dcache_pkg::IDLE;
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q   <= dcache_pkg::IDLE;
            up_q      <= 1'b0;
            mem_req_q <= 1'b0;
            mem_we_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            up_q    <= 1'b1;
            // One line request per bus state until done
            if (mem.done) begin
                mem_req_q <= 1'b0;
            end else if ((state_d == dcache_pkg::WRITEBACK || state_d == dcache_pkg::REFILL)
                         && !mem_req_q) begin
                mem_req_q <= 1'b1;
                mem_we_q  <= (state_d == dcache_pkg::WRITEBACK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= cpu_op;
            addr_q  <= cpu_addr;
            wdata_q <= cpu_wdata;
            wstrb_q <= cpu_wstrb;
        end
        if (state_q == dcache_pkg::LOOKUP && !arr.hit) begin
            way_q <= arr.victim_way;
        end
        if (state_q == dcache_pkg::MAINT) begin
            way_q <= sel_way;
        end
        if (state_q == dcache_pkg::REFILL && mem.done) begin
            line_q <= mem.rline;
        end
    end

endmodule

// File: design/dcache_ifs.sv
`timescale 1ns/1ns

interface array_if;
    localparam int LINE_W = dcache_pkg::WORDS_PER_LINE * wb_pkg::DAT_W;

    logic [wb_pkg::ADR_W-1:0] addr;
    dcache_pkg::array_cmd_e   cmd;
    logic                     way;
    logic [wb_pkg::DAT_W-1:0] wdata;
    logic [wb_pkg::SEL_W-1:0] wstrb;
    logic [LINE_W-1:0]        fill_line;
    logic                     fill_dirty;

    logic                     hit;
    logic                     hit_way;
    logic [wb_pkg::DAT_W-1:0] rdata;
    // victim_way is the replacement pick while the other victim fields describe the line in way
    logic                     victim_way;
    logic                     victim_valid;
    logic                     victim_dirty;
    logic [wb_pkg::ADR_W-1:0] victim_addr;
    logic [LINE_W-1:0]        victim_line;

    modport ctrl (
        output addr, cmd, way, wdata, wstrb, fill_line, fill_dirty,
        input  hit, hit_way, rdata, victim_way, victim_valid, victim_dirty,
        input  victim_addr, victim_line
    );

    modport store (
        input  addr, cmd, way, wdata, wstrb, fill_line, fill_dirty,
        output hit, hit_way, rdata, victim_way, victim_valid, victim_dirty,
        output victim_addr, victim_line
    );
endinterface

interface line_mem_if;
    localparam int LINE_W = dcache_pkg::WORDS_PER_LINE * wb_pkg::DAT_W;

    logic                     req;
    logic                     we;
    logic [wb_pkg::ADR_W-1:0] addr;
    logic [LINE_W-1:0]        wline;
    logic [LINE_W-1:0]        rline;
    logic                     done;

    modport ctrl (output req, we, addr, wline, input rline, done);
    modport port (input req, we, addr, wline, output rline, done);
endinterface

// File: design/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int NUM_WAYS       = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 4;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_INDEX_INV,
        OP_HIT_INV
    } cpu_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        COMMIT,
        MAINT,
        DONE
    } ctrl_state_e;

    // Commands applied by the arrays at the next rising edge
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_STORE,
        CMD_FILL,
        CMD_INVALIDATE
    } array_cmd_e;

endpackage

// File: design/dcache_top.sv
`timescale 1ns/1ns

module dcache_top #(
    parameter int NUM_SETS = 16
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     cpu_req,
    input  dcache_pkg::cpu_op_e      cpu_op,
    input  logic [wb_pkg::ADR_W-1:0] cpu_addr,
    input  logic [wb_pkg::DAT_W-1:0] cpu_wdata,
    input  logic [wb_pkg::SEL_W-1:0] cpu_wstrb,
    output logic                     cpu_ready,
    output logic                     cpu_done,
    output logic [wb_pkg::DAT_W-1:0] cpu_rdata,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [wb_pkg::ADR_W-1:0] wb_adr,
    output logic [wb_pkg::SEL_W-1:0] wb_sel,
    output logic [wb_pkg::DAT_W-1:0] wb_dat_w,
    input  logic [wb_pkg::DAT_W-1:0] wb_dat_r,
    input  logic                     wb_ack
);
    array_if    arr ();
    line_mem_if mem ();

    dcache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .cpu_req   (cpu_req),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_wstrb (cpu_wstrb),
        .cpu_ready (cpu_ready),
        .cpu_done  (cpu_done),
        .cpu_rdata (cpu_rdata),
        .arr       (arr.ctrl),
        .mem       (mem.ctrl)
    );

    dcache_array #(
        .NUM_SETS (NUM_SETS)
    ) u_array (
        .clk  (clk),
        .rstn (rstn),
        .arr  (arr.store)
    );

    wb_line_port u_port (
        .clk      (clk),
        .rstn     (rstn),
        .mem      (mem.port),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

// File: design/wb_line_port.sv
`timescale 1ns/1ns

module wb_line_port (
    input  logic                     clk,
    input  logic                     rstn,
    line_mem_if.port                 mem,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [wb_pkg::ADR_W-1:0] wb_adr,
    output logic [wb_pkg::SEL_W-1:0] wb_sel,
    output logic [wb_pkg::DAT_W-1:0] wb_dat_w,
    input  logic [wb_pkg::DAT_W-1:0] wb_dat_r,
    input  logic                     wb_ack
);
    localparam int WORD_IDX_W = $clog2(dcache_pkg::WORDS_PER_LINE);
    localparam int BYTE_BITS  = dcache_pkg::OFFSET_BITS - WORD_IDX_W;
    localparam int LINE_W     = dcache_pkg::WORDS_PER_LINE * wb_pkg::DAT_W;

    typedef enum logic [1:0] {
        P_IDLE,
        P_CYC,
        P_GAP,
        P_DONE
    } port_state_e;

    port_state_e           state_q;
    logic [WORD_IDX_W-1:0] cnt_q;
    logic [LINE_W-1:0]     rline_q;

    assign wb_cyc   = (state_q == P_CYC) || (state_q == P_GAP);
    assign wb_stb   = (state_q == P_CYC);
    assign wb_we    = wb_cyc && mem.we;
    assign wb_adr   = {mem.addr[wb_pkg::ADR_W-1:dcache_pkg::OFFSET_BITS], cnt_q,
                       {BYTE_BITS{1'b0}}};
    assign wb_sel   = {wb_pkg::SEL_W{1'b1}};
    assign wb_dat_w = mem.wline[cnt_q*wb_pkg::DAT_W +: wb_pkg::DAT_W];

    assign mem.done  = (state_q == P_DONE);
    assign mem.rline = rline_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= P_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                P_IDLE: begin
                    if (mem.req) begin
                        state_q <= P_CYC;
                        cnt_q   <= '0;
                    end
                end
                P_CYC: begin
                    if (wb_ack) begin
                        if (cnt_q == WORD_IDX_W'(dcache_pkg::WORDS_PER_LINE - 1)) begin
                            state_q <= P_DONE;
                        end else begin
                            state_q <= P_GAP;
                            cnt_q   <= cnt_q + 1'b1;
                        end
                    end
                end
                P_GAP:   state_q <= P_CYC;
                default: state_q <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == P_CYC && wb_ack && !mem.we) begin
            rline_q[cnt_q*wb_pkg::DAT_W +: wb_pkg::DAT_W] <= wb_dat_r;
        end
    end

endmodule

// File: design/wb_pkg.sv
package wb_pkg;

    // Wishbone classic bus widths
    localparam int ADR_W = 32;
    localparam int DAT_W = 32;
    localparam int SEL_W = 4;

endpackage

// File: list.f
design/dcache_pkg.sv
design/wb_pkg.sv
design/dcache_ifs.sv
design/dcache_array.sv
design/wb_line_port.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/tb_clock.sv
sim/wb_mem_model.sv
sim/dcache_assert.sv
sim/tb_dcache.sv

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dcache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: sim/dcache_assert.sv
`timescale 1ns/1ns

module dcache_assert (
    input logic                     clk,
    input logic                     rstn,
    input logic                     cpu_done,
    input logic                     wb_cyc,
    input logic                     wb_stb,
    input logic                     wb_ack,
    input logic [wb_pkg::ADR_W-1:0] wb_adr
);
    int fail_count = 0;

    stb_in_cycle: assert property (@(posedge clk) disable iff (!rstn) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb is high outside a bus cycle");
            fail_count++;
        end

    done_in_reset: assert property (@(posedge clk) !rstn |-> !cpu_done)
        else begin
            $error("cpu_done is high during reset");
            fail_count++;
        end

    // Address held until the slave acknowledges
    adr_stable: assert property (@(posedge clk) disable iff (!rstn)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else begin
            $error("wb_adr changed while waiting for wb_ack");
            fail_count++;
        end
endmodule

// File: sim/dcache_tests.txt
# op addr data mask expect, R read, W write, H hit invalidate, I index invalidate
# C compares write cycles since the previous C line with expect, other columns unused
R 00000040 00000000 0 a5000010
R 00000044 00000000 0 a5000011
R 00000040 00000000 0 a5000010
W 00000048 11223344 5 00000000
R 00000048 00000000 0 a5220044
C 00000000 00000000 0 00000000
W 00000014 deadbeef f 00000000
R 00000110 00000000 0 a5000044
R 00000210 00000000 0 a5000084
C 00000000 00000000 0 00000004
R 00000014 00000000 0 deadbeef
R 00000018 00000000 0 a5000006
W 0000008c 12345678 f 00000000
H 00000080 00000000 0 00000000
C 00000000 00000000 0 00000004
R 0000008c 00000000 0 12345678
I 00000080 00000000 0 00000000
C 00000000 00000000 0 00000000
R 0000008c 00000000 0 12345678

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end
endmodule

// File: sim/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;
    localparam int READY_LIMIT = 100;
    localparam int DONE_LIMIT  = 200;

    logic                     clk;
    logic                     rstn;
    logic                     cpu_req;
    dcache_pkg::cpu_op_e      cpu_op;
    logic [wb_pkg::ADR_W-1:0] cpu_addr;
    logic [wb_pkg::DAT_W-1:0] cpu_wdata;
    logic [wb_pkg::SEL_W-1:0] cpu_wstrb;
    logic                     cpu_ready;
    logic                     cpu_done;
    logic [wb_pkg::DAT_W-1:0] cpu_rdata;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_pkg::ADR_W-1:0] wb_adr;
    logic [wb_pkg::SEL_W-1:0] wb_sel;
    logic [wb_pkg::DAT_W-1:0] wb_dat_w;
    logic [wb_pkg::DAT_W-1:0] wb_dat_r;
    logic                     wb_ack;
    int                       mem_writes;

    tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

    dcache_top #(
        .NUM_SETS (16)
    ) UUT (
        .clk       (clk),
        .rstn      (rstn),
        .cpu_req   (cpu_req),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_wstrb (cpu_wstrb),
        .cpu_ready (cpu_ready),
        .cpu_done  (cpu_done),
        .cpu_rdata (cpu_rdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    wb_mem_model u_mem (
        .clk         (clk),
        .rstn        (rstn),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_sel      (wb_sel),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .write_count (mem_writes)
    );

    bind dcache_top dcache_assert u_assert (
        .clk      (clk),
        .rstn     (rstn),
        .cpu_done (cpu_done),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack),
        .wb_adr   (wb_adr)
    );

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Error at %0t ns: %s expected %h, got %h",
                                      $time, what, expected, actual));
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cpu_ready) begin
            if (cycles >= READY_LIMIT) begin
                stop_on_failure("Timeout: the cache never raised cpu_ready");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_done(output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cpu_done) begin
            if (cycles >= DONE_LIMIT) begin
                stop_on_failure("Timeout: the request never finished with cpu_done");
            end
            cycles++;
            @(negedge clk);
        end
        rdata = cpu_rdata;
    endtask

    task automatic run_request(input dcache_pkg::cpu_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] wstrb,
                               output logic [31:0] rdata);
        wait_ready();
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_op    <= op;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        cpu_wstrb <= wstrb;
        // Ready was already high, so the next edge accepts the request
        @(posedge clk);
        cpu_req <= 1'b0;
        wait_done(rdata);
    endtask

    initial begin
        int          fd;
        int          line_no;
        int          fields;
        int          last_writes;
        string       line;
        byte         kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] expected;
        logic [31:0] rdata;

        rstn      <= 1'b0;
        cpu_req   <= 1'b0;
        cpu_op    <= dcache_pkg::OP_READ;
        cpu_addr  <= '0;
        cpu_wdata <= '0;
        cpu_wstrb <= '0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        fd = $fopen("sim/dcache_tests.txt", "r");
        if (fd == 0) begin
            stop_on_failure("Could not open the tests file sim/dcache_tests.txt");
        end
        line_no     = 0;
        last_writes = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() < 2) begin
                continue;
            end
            kind = line.getc(0);
            if (kind == "#") begin
                continue;
            end
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                             addr, wdata, wstrb, expected);
            if (fields != 4) begin
                stop_on_failure($sformatf("Line %0d of the tests file is malformed", line_no));
            end
            case (kind)
                "R": begin
                    run_request(dcache_pkg::OP_READ, addr, wdata, wstrb, rdata);
                    check_value($sformatf("line %0d read data", line_no), expected, rdata);
                end
                "W": run_request(dcache_pkg::OP_WRITE, addr, wdata, wstrb, rdata);
                "H": run_request(dcache_pkg::OP_HIT_INV, addr, wdata, wstrb, rdata);
                "I": run_request(dcache_pkg::OP_INDEX_INV, addr, wdata, wstrb, rdata);
                "C": begin
                    check_value($sformatf("line %0d write cycles", line_no), expected,
                                32'(mem_writes - last_writes));
                    last_writes = mem_writes;
                end
                default: begin
                    stop_on_failure($sformatf("Unknown operation on line %0d", line_no));
                end
            endcase
        end
        $fclose(fd);

        if (UUT.u_assert.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_failure("Bus protocol assertions failed during the run");
        end
    end
endmodule

// File: sim/wb_mem_model.sv
`timescale 1ns/1ns

module wb_mem_model #(
    parameter int DEPTH = 1024
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_pkg::ADR_W-1:0] wb_adr,
    input  logic [wb_pkg::SEL_W-1:0] wb_sel,
    input  logic [wb_pkg::DAT_W-1:0] wb_dat_w,
    output logic [wb_pkg::DAT_W-1:0] wb_dat_r,
    output logic                     wb_ack,
    output int                       write_count
);
    localparam int IDX_W = $clog2(DEPTH);

    logic [wb_pkg::DAT_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]         word_idx;
    logic                     write_ack;

    assign word_idx  = wb_adr[IDX_W+1:2];
    assign wb_dat_r  = mem[word_idx];
    assign write_ack = wb_cyc && wb_stb && wb_ack && wb_we;

    initial begin
        wb_ack      = 1'b0;
        write_count = 0;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'ha500_0000 + i;
        end
    end

    // One wait state per word cycle
    always @(posedge clk) begin
        if (!rstn) begin
            wb_ack      <= 1'b0;
            write_count <= 0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
            if (write_ack) begin
                write_count <= write_count + 1;
                for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                    if (wb_sel[b]) begin
                        mem[word_idx][b*8 +: 8] <= wb_dat_w[b*8 +: 8];
                    end
                end
            end
        end
    end
endmodule
